/* hdl/video_defs.svh */
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

//////////////////////////////
// Horizontal timing
//////////////////////////////

// Phase lengths in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_PULSE 96
`define H_BACK 48

//////////////////////////////
// Vertical timing
//////////////////////////////

// Phase lengths in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_PULSE 2
`define V_BACK 33

//////////////////////////////
// Frame store geometry
//////////////////////////////

// One word per visible pixel
`define FB_DEPTH (`H_ACTIVE * `V_ACTIVE)
// Coordinate and linear address widths
`define COORD_W 10
`define FB_ADDR_W 19

`endif

/* hdl/video_pkg.sv */
`default_nettype none

`include "video_defs.svh"

package video_pkg;

	// Screen coordinate, x or y
	typedef logic [`COORD_W-1:0] coord_t;

	// Linear frame store address, y * width + x
	typedef logic [`FB_ADDR_W-1:0] fb_addr_t;

	// 12-bit pixel color, red in the top nibble
	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} color_t;

	// Scan phase, shared by horizontal and vertical machines
	// Order matters, the machines step by incrementing
	typedef enum logic [1:0] {
		ACTIVE = 2'd0,
		FRONT  = 2'd1,
		PULSE  = 2'd2,
		BACK   = 2'd3
	} phase_t;

endpackage

`default_nettype wire

/* hdl/scan_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Scan position and sync levels, scan generator to frame store
interface scan_if;

	// Position, zero outside the visible area
	video_pkg::coord_t x;
	video_pkg::coord_t y;
	// Visible-area qualifiers per axis
	logic h_active;
	logic v_active;
	// Syncs, low during the pulse phase
	logic hsync_n;
	logic vsync_n;

	// Driven by the scan generator
	modport source (output x, output y, output h_active, output v_active,
		output hsync_n, output vsync_n);

	// Read by the frame store
	modport sink (input x, input y, input h_active, input v_active,
		input hsync_n, input vsync_n);

endinterface

`default_nettype wire

/* hdl/pixel_if.sv */
`timescale 1ns/1ns
`default_nettype none

// Fetched color plus levels delayed to match it
interface pixel_if;

	// Color read from the frame store
	video_pkg::color_t color;
	// Both axes inside the visible area
	logic active;
	// Syncs, same delay as color
	logic hsync_n;
	logic vsync_n;

	// Driven by the frame store read stage
	modport source (output color, output active, output hsync_n,
		output vsync_n);

	// Read by the output register stage
	modport sink (input color, input active, input hsync_n,
		input vsync_n);

endinterface

`default_nettype wire

/* hdl/scan_timing.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defs.svh"

module scan_timing (
	input logic M10k_pll,
	input logic reset,
	scan_if.source scan
);

	// Horizontal machine
	video_pkg::phase_t h_phase;
	video_pkg::coord_t h_count;
	video_pkg::coord_t h_len;
	logic h_last;
	logic h_active;

	// Vertical machine
	video_pkg::phase_t v_phase;
	video_pkg::coord_t v_count;
	video_pkg::coord_t v_len;
	logic v_last;
	logic v_active;

	// Last clock of the back porch, next clock starts a new line
	logic line_wrap;

	// Length of a phase, picked from the four given lengths
	function automatic video_pkg::coord_t phase_len(input video_pkg::phase_t phase,
		input int len_active, input int len_front, input int len_pulse,
		input int len_back);
		video_pkg::coord_t len;
		case (phase)
			video_pkg::ACTIVE: len = video_pkg::coord_t'(len_active);
			video_pkg::FRONT:  len = video_pkg::coord_t'(len_front);
			video_pkg::PULSE:  len = video_pkg::coord_t'(len_pulse);
			default:           len = video_pkg::coord_t'(len_back);
		endcase
		return len;
	endfunction

	assign h_len = phase_len(h_phase, `H_ACTIVE, `H_FRONT, `H_PULSE, `H_BACK);
	assign v_len = phase_len(v_phase, `V_ACTIVE, `V_FRONT, `V_PULSE, `V_BACK);

	assign h_last = (h_count == h_len - 1'b1);
	assign v_last = (v_count == v_len - 1'b1);
	assign line_wrap = h_last && (h_phase == video_pkg::BACK);

	//////////////////////////////
	// Phase machines
	//////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			// Park at the top left visible pixel
			h_count <= '0;
			h_phase <= video_pkg::ACTIVE;
			v_count <= '0;
			v_phase <= video_pkg::ACTIVE;
		end else begin
			// Pixel step
			if (h_last) begin
				h_count <= '0;
				// BACK rolls over to ACTIVE in two bits
				h_phase <= video_pkg::phase_t'(h_phase + 2'd1);
			end else begin
				h_count <= h_count + 1'b1;
			end
			// Line step, only on the horizontal wrap
			if (line_wrap) begin
				if (v_last) begin
					v_count <= '0;
					v_phase <= video_pkg::phase_t'(v_phase + 2'd1);
				end else begin
					v_count <= v_count + 1'b1;
				end
			end
		end
	end

	//////////////////////////////
	// Scan outputs
	//////////////////////////////

	assign h_active = (h_phase == video_pkg::ACTIVE);
	assign v_active = (v_phase == video_pkg::ACTIVE);

	// Coordinates held at zero in the porches and pulses
	assign scan.x = h_active ? h_count : '0;
	assign scan.y = v_active ? v_count : '0;
	assign scan.h_active = h_active;
	assign scan.v_active = v_active;
	assign scan.hsync_n = (h_phase != video_pkg::PULSE);
	assign scan.vsync_n = (v_phase != video_pkg::PULSE);

	// Counter stays inside the phase it is timing
	h_count_in_phase: assert property (@(posedge M10k_pll) disable iff (reset)
		h_count < h_len);

	// Vertical phase moves only when a line ends
	v_phase_on_wrap: assert property (@(posedge M10k_pll) disable iff (reset)
		!$stable(v_phase) |-> $past(line_wrap));

endmodule

`default_nettype wire

/* hdl/frame_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defs.svh"

module frame_buffer (
	input logic M10k_pll,
	input logic reset,
	scan_if.sink scan,
	pixel_if.source pixel,
	input logic write_en,
	input video_pkg::coord_t write_x,
	input video_pkg::coord_t write_y,
	input video_pkg::color_t write_color
);

	// One color word per visible pixel, mapped to M10K
	(* ramstyle = "M10K" *) video_pkg::color_t mem [0:`FB_DEPTH-1];

	video_pkg::fb_addr_t wr_addr;
	video_pkg::fb_addr_t rd_addr;
	video_pkg::color_t rd_color;

	// Levels delayed one clock to sit beside rd_color
	logic active_q;
	logic hsync_n_q;
	logic vsync_n_q;

	// Row-major address
	function automatic video_pkg::fb_addr_t lin_addr(input video_pkg::coord_t x,
		input video_pkg::coord_t y);
		return video_pkg::fb_addr_t'(y) * video_pkg::fb_addr_t'(`H_ACTIVE)
			+ video_pkg::fb_addr_t'(x);
	endfunction

	assign wr_addr = lin_addr(write_x, write_y);
	// Scan coordinates are zero off screen, so this stays in range
	assign rd_addr = lin_addr(scan.x, scan.y);

	// Host write port and scan read port
	always_ff @(posedge M10k_pll) begin
		if (write_en) begin
			mem[wr_addr] <= write_color;
		end
		// Old data on a same-address collision
		rd_color <= mem[rd_addr];
	end

	// Level delay, idle values in reset
	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			active_q <= 1'b0;
			hsync_n_q <= 1'b1;
			vsync_n_q <= 1'b1;
		end else begin
			active_q <= scan.h_active && scan.v_active;
			hsync_n_q <= scan.hsync_n;
			vsync_n_q <= scan.vsync_n;
		end
	end

	assign pixel.color = rd_color;
	assign pixel.active = active_q;
	assign pixel.hsync_n = hsync_n_q;
	assign pixel.vsync_n = vsync_n_q;

	// Host only writes visible pixels
	write_in_area: assert property (@(posedge M10k_pll) disable iff (reset)
		write_en |-> (write_x < `H_ACTIVE) && (write_y < `V_ACTIVE));

endmodule

`default_nettype wire

/* hdl/video_out.sv */
`timescale 1ns/1ns
`default_nettype none

module video_out (
	input logic M10k_pll,
	input logic reset,
	pixel_if.sink pixel,
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank_n
);

	// 4-bit channel to 8 bits, zeros in the low nibble
	function automatic logic [7:0] widen(input logic [3:0] chan);
		return {chan, 4'h0};
	endfunction

	//////////////////////////////
	// Pin registers
	//////////////////////////////

	always_ff @(posedge M10k_pll) begin
		if (reset) begin
			// Black, blanked, syncs inactive
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
			vga_hs <= 1'b1;
			vga_vs <= 1'b1;
			vga_blank_n <= 1'b0;
		end else begin
			vga_hs <= pixel.hsync_n;
			vga_vs <= pixel.vsync_n;
			// Blank tracks the visible area
			vga_blank_n <= pixel.active;
			if (pixel.active) begin
				vga_r <= widen(pixel.color.r);
				vga_g <= widen(pixel.color.g);
				vga_b <= widen(pixel.color.b);
			end else begin
				vga_r <= '0;
				vga_g <= '0;
				vga_b <= '0;
			end
		end
	end

	// Nothing but black while blanked
	rgb_black_when_blank: assert property (@(posedge M10k_pll) disable iff (reset)
		!vga_blank_n |-> ({vga_r, vga_g, vga_b} == '0));

endmodule

`default_nettype wire

/* hdl/raster_display.sv */
`timescale 1ns/1ns
`default_nettype none

module raster_display (
	input logic M10k_pll,
	input logic reset,
	// Host pixel writes
	input logic fb_write_en,
	input video_pkg::coord_t fb_write_x,
	input video_pkg::coord_t fb_write_y,
	input video_pkg::color_t fb_write_color,
	// VGA pins
	output logic [7:0] vga_r,
	output logic [7:0] vga_g,
	output logic [7:0] vga_b,
	output logic vga_hs,
	output logic vga_vs,
	output logic vga_blank_n
);

	// Stage links
	scan_if scan_bus ();
	pixel_if pixel_bus ();

	// Position and syncs, stage 0
	scan_timing u_scan_timing (
		.M10k_pll (M10k_pll),
		.reset    (reset),
		.scan     (scan_bus.source)
	);

	// Color fetch, one clock
	frame_buffer u_frame_buffer (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.scan        (scan_bus.sink),
		.pixel       (pixel_bus.source),
		.write_en    (fb_write_en),
		.write_x     (fb_write_x),
		.write_y     (fb_write_y),
		.write_color (fb_write_color)
	);

	// Pin registers, one more clock
	video_out u_video_out (
		.M10k_pll    (M10k_pll),
		.reset       (reset),
		.pixel       (pixel_bus.sink),
		.vga_r       (vga_r),
		.vga_g       (vga_g),
		.vga_b       (vga_b),
		.vga_hs      (vga_hs),
		.vga_vs      (vga_vs),
		.vga_blank_n (vga_blank_n)
	);

endmodule

`default_nettype wire

/* sim/tb_raster_display.sv */
`timescale 1ns/1ns
`default_nettype none

`include "video_defs.svh"

module tb_raster_display;

	localparam int NUM_CASES = 10;
	localparam int LINE_CLKS = `H_ACTIVE + `H_FRONT + `H_PULSE + `H_BACK;
	localparam int FRAME_CLKS = LINE_CLKS * (`V_ACTIVE + `V_FRONT + `V_PULSE + `V_BACK);

	logic M10k_pll;
	logic reset;
	logic fb_write_en;
	video_pkg::coord_t fb_write_x;
	video_pkg::coord_t fb_write_y;
	video_pkg::color_t fb_write_color;
	logic [7:0] vga_r;
	logic [7:0] vga_g;
	logic [7:0] vga_b;
	logic vga_hs;
	logic vga_vs;
	logic vga_blank_n;

	// Case table of three words per file line
	logic [11:0] cases_mem [0:3*NUM_CASES-1];
	video_pkg::coord_t case_x [NUM_CASES];
	video_pkg::coord_t case_y [NUM_CASES];
	logic [11:0] case_color [NUM_CASES];
	int order [NUM_CASES];

	// Run bookkeeping
	int errors = 0;
	int checks = 0;
	int tests = 0;
	logic aborted = 1'b0;
	int cycle = 0;
	int high_count = 0;
	int run_count = 0;
	int blank_checks = 0;
	logic prev_blank = 1'b0;

	raster_display DUT (
		.M10k_pll       (M10k_pll),
		.reset          (reset),
		.fb_write_en    (fb_write_en),
		.fb_write_x     (fb_write_x),
		.fb_write_y     (fb_write_y),
		.fb_write_color (fb_write_color),
		.vga_r          (vga_r),
		.vga_g          (vga_g),
		.vga_b          (vga_b),
		.vga_hs         (vga_hs),
		.vga_vs         (vga_vs),
		.vga_blank_n    (vga_blank_n)
	);

	initial begin
		M10k_pll = 1'b0;
		forever #10 M10k_pll = ~M10k_pll;
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("FAIL t=%0t %s expected %0h got %0h", $time, name, expected, actual);
		end
	endtask

	// 4-bit channels with four low zero bits
	function automatic logic [23:0] widened(input logic [11:0] c);
		return {c[11:8], 4'h0, c[7:4], 4'h0, c[3:0], 4'h0};
	endfunction

	// One clock sampled on the falling edge
	// Also counts visible clocks and visible runs, and checks blanked RGB
	task automatic step_clock();
		@(negedge M10k_pll);
		cycle++;
		if (vga_blank_n) begin
			high_count++;
		end else begin
			blank_checks++;
			compare("vga_rgb while blanked", 32'h0, {vga_r, vga_g, vga_b});
		end
		if (vga_blank_n && !prev_blank)
			run_count++;
		prev_blank = vga_blank_n;
	endtask

	task automatic check_idle_pins();
		step_clock();
		compare("vga_hs", 1, vga_hs);
		compare("vga_vs", 1, vga_vs);
		compare("vga_blank_n", 0, vga_blank_n);
		compare("vga_rgb", 0, {vga_r, vga_g, vga_b});
	endtask

	// Step until a sync reaches a level or the limit runs out
	task automatic wait_sync(input logic use_vs, input logic level, input int limit,
		input string what);
		int waited;
		waited = 0;
		while (!aborted && ((use_vs ? vga_vs : vga_hs) !== level)) begin
			step_clock();
			waited++;
			if (waited > limit) begin
				$display("Timeout: %s did not happen within %0d clocks", what, limit);
				aborted = 1'b1;
			end
		end
	endtask

	// Drive 1 ns after the rising edge
	task automatic write_pixel(input logic en, input video_pkg::coord_t x,
		input video_pkg::coord_t y, input logic [11:0] color);
		@(posedge M10k_pll);
		#1;
		fb_write_en = en;
		fb_write_x = x;
		fb_write_y = y;
		fb_write_color = color;
		step_clock();
	endtask

	// Walk one visible frame from the vsync rise and check every case pixel
	task automatic scan_frame_check();
		int n;
		int k;
		int waited;
		n = 0;
		waited = 0;
		while (!aborted && n < `FB_DEPTH) begin
			step_clock();
			waited++;
			if (vga_blank_n) begin
				for (k = 0; k < NUM_CASES; k++) begin
					if (n % `H_ACTIVE == case_x[k] && n / `H_ACTIVE == case_y[k])
						compare($sformatf("vga_rgb (%0d,%0d)", case_x[k], case_y[k]),
							widened(case_color[k]), {vga_r, vga_g, vga_b});
				end
				n++;
			end
			if (waited > FRAME_CLKS) begin
				$display("Timeout: only %0d visible pixels seen in one frame", n);
				aborted = 1'b1;
			end
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		$display("test %-16s done, %0d mismatches", name, errors - errs_before);
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial begin
		int e0;
		int c0;
		int r0;
		int h0;
		int vs_low;
		int i;
		int j;
		int tmp;
		int k;
		reset = 1'b1;
		fb_write_en = 1'b0;
		fb_write_x = '0;
		fb_write_y = '0;
		fb_write_color = '0;
		void'($urandom(32'hf33f_a758));
		$readmemh("sim/fb_cases.txt", cases_mem);
		if (^cases_mem[3*NUM_CASES-1] === 1'bx) begin
			$display("Case file sim/fb_cases.txt is missing or short");
			aborted = 1'b1;
		end
		for (i = 0; i < NUM_CASES; i++) begin
			case_x[i] = video_pkg::coord_t'(cases_mem[3*i]);
			case_y[i] = video_pkg::coord_t'(cases_mem[3*i+1]);
			case_color[i] = cases_mem[3*i+2];
			order[i] = i;
		end
		// Shuffled write order
		for (i = NUM_CASES - 1; i > 0; i--) begin
			j = $urandom % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end

		// Reset held for 4 rising edges and idle pins for one clock more
		e0 = errors;
		repeat (3) check_idle_pins();
		@(posedge M10k_pll);
		#1;
		reset = 1'b0;
		check_idle_pins();
		check_idle_pins();
		report_test("reset state", e0);

		// Line timing from one hsync fall to the next
		e0 = errors;
		wait_sync(1'b0, 1'b1, LINE_CLKS, "hsync high");
		wait_sync(1'b0, 1'b0, LINE_CLKS, "hsync fall");
		c0 = cycle;
		h0 = high_count;
		wait_sync(1'b0, 1'b1, LINE_CLKS, "hsync rise");
		compare("hsync low clocks", `H_PULSE, cycle - c0);
		wait_sync(1'b0, 1'b0, LINE_CLKS, "hsync fall");
		compare("line clocks", LINE_CLKS, cycle - c0);
		compare("blank_n high per line", `H_ACTIVE, high_count - h0);
		if (!aborted)
			report_test("line timing", e0);

		// Writes go in during the first vsync pulse
		wait_sync(1'b1, 1'b0, FRAME_CLKS, "first vsync fall");
		e0 = errors;
		c0 = cycle;
		r0 = run_count;
		for (i = 0; i < NUM_CASES && !aborted; i++)
			write_pixel(1'b1, case_x[order[i]], case_y[order[i]], case_color[order[i]]);
		write_pixel(1'b0, '0, '0, 12'h0);
		wait_sync(1'b1, 1'b1, 2 * LINE_CLKS, "vsync rise");
		vs_low = cycle - c0;
		scan_frame_check();
		if (!aborted)
			report_test("pixel readback", e0);
		e0 = errors;
		wait_sync(1'b1, 1'b0, FRAME_CLKS, "vsync fall");
		compare("vsync low clocks", `V_PULSE * LINE_CLKS, vs_low);
		compare("frame clocks", FRAME_CLKS, cycle - c0);
		compare("visible lines per frame", `V_ACTIVE, run_count - r0);
		if (!aborted)
			report_test("frame timing", e0);

		// Complement one case pixel in the next blanking
		e0 = errors;
		k = $urandom % NUM_CASES;
		case_color[k] = ~case_color[k];
		write_pixel(1'b1, case_x[k], case_y[k], case_color[k]);
		write_pixel(1'b0, '0, '0, 12'h0);
		wait_sync(1'b1, 1'b1, 2 * LINE_CLKS, "vsync rise after rewrite");
		scan_frame_check();
		if (!aborted)
			report_test("rewrite", e0);

		$display("test %-16s done, %0d blanked clocks checked", "blanking", blank_checks);
		tests++;
		$display("tests=%0d checks=%0d errors=%0d aborted=%0d", tests, checks, errors,
			aborted);
		if (errors == 0 && !aborted) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hdl
hdl/video_pkg.sv
hdl/scan_if.sv
hdl/pixel_if.sv
hdl/scan_timing.sv
hdl/frame_buffer.sv
hdl/video_out.sv
hdl/raster_display.sv
sim/tb_raster_display.sv

/* sim/fb_cases.txt */
// Pixel cases for frame store readback
// Columns: x, y, color as r g b nibbles, all hex
000 000 f00
27f 000 0f0
000 1df 00f
27f 1df fff
140 0f0 a5c
001 000 123
000 001 456
13f 0ef 789
200 100 0e7
0a3 15c c30
